// ==== all.f ====
+incdir+src
src/rv_isa_pkg.sv
src/fetch_pkg.sv
src/instruction_predecode.sv
src/direct_icache.sv
src/fetch_unit.sv
src/fetch_top.sv
test/tb_clock_gen.sv
test/tb_fetch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the fetch stage testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
	--top-module tb_fetch -o tb_fetch &&
./obj_dir/tb_fetch | tee /dev/stderr | grep -qx "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== src/direct_icache.sv ====
// Direct-mapped instruction cache with one-word lines
// Hits are combinational; a miss runs one four-phase req/ack refill

`timescale 1ns/1ps

`include "fetch_config.svh"

module direct_icache (
	input logic i_clock,
	input logic i_reset,
	input rv_isa_pkg::address_t i_pc,
	output rv_isa_pkg::instruction_t o_rdata,
	output logic o_ready,
	output logic o_mem_req,
	output rv_isa_pkg::address_t o_mem_address,
	input logic i_mem_ack,
	input rv_isa_pkg::instruction_t i_mem_rdata
);
	import rv_isa_pkg::*;

	localparam int LINES = `FETCH_ICACHE_LINES;
	localparam int INDEX_BITS = $clog2(LINES);
	localparam int TAG_BITS = `FETCH_MEM_ADDR_WIDTH - INDEX_BITS - 2;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_REQUEST,
		BUS_RELEASE
	} bus_state_t;

	bus_state_t bus_state;
	logic [LINES-1:0] line_valid;
	logic [TAG_BITS-1:0] line_tag [LINES];
	instruction_t line_word [LINES];
	address_t refill_address;

	logic [INDEX_BITS-1:0] pc_index;
	logic [TAG_BITS-1:0] pc_tag;
	logic [INDEX_BITS-1:0] refill_index;
	logic [TAG_BITS-1:0] refill_tag;
	logic hit;
	logic start;
	logic fill;

	assign pc_index = i_pc[INDEX_BITS+1:2];
	assign pc_tag = i_pc[`FETCH_MEM_ADDR_WIDTH-1:INDEX_BITS+2];
	assign refill_index = refill_address[INDEX_BITS+1:2];
	assign refill_tag = refill_address[`FETCH_MEM_ADDR_WIDTH-1:INDEX_BITS+2];

	assign hit = line_valid[pc_index] && line_tag[pc_index] == pc_tag;
	assign o_ready = hit;
	assign o_rdata = line_word[pc_index];
	assign o_mem_address = refill_address;

	// New request only once the memory has let go of ack
	assign start = bus_state == BUS_IDLE && !hit && !i_mem_ack;
	assign fill = bus_state == BUS_REQUEST && i_mem_ack;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			bus_state <= BUS_IDLE;
			o_mem_req <= 1'b0;
			line_valid <= '0;
		end else begin
			case (bus_state)
				BUS_IDLE: begin
					if (start) begin
						o_mem_req <= 1'b1;
						bus_state <= BUS_REQUEST;
					end
				end
				BUS_REQUEST: begin
					// Word lands in the line it was requested for
					if (fill) begin
						o_mem_req <= 1'b0;
						line_valid[refill_index] <= 1'b1;
						bus_state <= BUS_RELEASE;
					end
				end
				BUS_RELEASE: begin
					if (!i_mem_ack) begin
						bus_state <= BUS_IDLE;
					end
				end
				default: begin
					o_mem_req <= 1'b0;
					bus_state <= BUS_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (start) begin
			refill_address <= {i_pc[31:2], 2'b00};
		end
		if (fill) begin
			line_tag[refill_index] <= refill_tag;
			line_word[refill_index] <= i_mem_rdata;
		end
	end

	mem_address_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_mem_req && $past(o_mem_req) |-> $stable(o_mem_address));

	mem_req_after_ack_low: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_mem_req) |-> !$past(i_mem_ack));

endmodule

// ==== src/fetch_config.svh ====
// Build-time settings for the fetch stage
// Included by the RTL modules that reset or size against them

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Pc loaded when reset is released
`define FETCH_RESET_VECTOR 32'h0000_0000

// Power-of-two count of one-word lines
`define FETCH_ICACHE_LINES 16

// Byte address width seen on the memory bus
`define FETCH_MEM_ADDR_WIDTH 32

`endif

// ==== src/fetch_pkg.sv ====
// Types on the fetch stage boundary
// The packet handed to decode and the fetch unit state encoding

package fetch_pkg;

	// Strobe toggles once per new packet
	// Absent operands read zero
	typedef struct packed {
		logic strobe;
		rv_isa_pkg::address_t pc;
		rv_isa_pkg::instruction_t instruction;
		rv_isa_pkg::register_t inst_rs1;
		rv_isa_pkg::register_t inst_rs2;
		rv_isa_pkg::register_t inst_rs3;
		rv_isa_pkg::register_t inst_rd;
	} fetch_data_t;

	typedef enum logic [1:0] {
		WAIT_ICACHE,
		WAIT_JUMP,
		WAIT_IRQ
	} fetch_state_t;

endpackage

// ==== src/fetch_top.sv ====
// Fetch stage top level
// Connects the instruction cache, the predecoder and the fetch unit

`timescale 1ns/1ps

module fetch_top (
	input logic i_clock,
	input logic i_reset,
	output logic o_mem_req,
	output rv_isa_pkg::address_t o_mem_address,
	input logic i_mem_ack,
	input rv_isa_pkg::instruction_t i_mem_rdata,
	input logic i_busy,
	output fetch_pkg::fetch_data_t o_data,
	input logic i_jump,
	input rv_isa_pkg::address_t i_jump_pc,
	input logic i_irq_pending,
	input rv_isa_pkg::address_t i_irq_pc,
	output logic o_irq_dispatched,
	output rv_isa_pkg::address_t o_irq_epc
);
	import rv_isa_pkg::*;

	address_t pc;
	instruction_t icache_rdata;
	logic icache_ready;
	inst_class_t inst_class;
	address_t j_imm;
	register_t rs1, rs2, rs3, rd;

	direct_icache direct_icache_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.o_rdata(icache_rdata),
		.o_ready(icache_ready),
		.o_mem_req(o_mem_req),
		.o_mem_address(o_mem_address),
		.i_mem_ack(i_mem_ack),
		.i_mem_rdata(i_mem_rdata)
	);

	// Decodes the word at the current pc and is valid whenever the cache hits
	instruction_predecode instruction_predecode_inst (
		.i_instruction(icache_rdata),
		.o_class(inst_class),
		.o_j_imm(j_imm),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.o_rs3(rs3),
		.o_rd(rd)
	);

	fetch_unit fetch_unit_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_icache_rdata(icache_rdata),
		.i_icache_ready(icache_ready),
		.i_class(inst_class),
		.i_j_imm(j_imm),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_rs3(rs3),
		.i_rd(rd),
		.o_pc(pc),
		.i_busy(i_busy),
		.o_data(o_data),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc)
	);

endmodule

// ==== src/fetch_unit.sv ====
// Program counter FSM of the fetch stage
// Issues packets on cache hits, takes fast jumps, waits for jumps and interrupts

`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_unit (
	input logic i_clock,
	input logic i_reset,
	input rv_isa_pkg::instruction_t i_icache_rdata,
	input logic i_icache_ready,
	input rv_isa_pkg::inst_class_t i_class,
	input rv_isa_pkg::address_t i_j_imm,
	input rv_isa_pkg::register_t i_rs1,
	input rv_isa_pkg::register_t i_rs2,
	input rv_isa_pkg::register_t i_rs3,
	input rv_isa_pkg::register_t i_rd,
	output rv_isa_pkg::address_t o_pc,
	input logic i_busy,
	output fetch_pkg::fetch_data_t o_data,
	input logic i_jump,
	input rv_isa_pkg::address_t i_jump_pc,
	input logic i_irq_pending,
	input rv_isa_pkg::address_t i_irq_pc,
	output logic o_irq_dispatched,
	output rv_isa_pkg::address_t o_irq_epc
);
	import rv_isa_pkg::*;
	import fetch_pkg::*;

	fetch_state_t state;
	address_t pc;
	fetch_data_t data;
	logic irq_pending_r;
	logic irq_edge;
	logic issue;

	assign irq_edge = i_irq_pending && !irq_pending_r;
	assign issue = i_icache_ready && !i_busy;
	assign o_pc = pc;
	assign o_data = data;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= WAIT_ICACHE;
			pc <= `FETCH_RESET_VECTOR;
			data <= '0;
			irq_pending_r <= 1'b0;
			o_irq_dispatched <= 1'b0;
			o_irq_epc <= '0;
		end else begin
			o_irq_dispatched <= 1'b0;

			case (state)
				WAIT_ICACHE: begin
					irq_pending_r <= i_irq_pending;
					// Interrupt wins over issuing
					if (irq_edge) begin
						o_irq_dispatched <= 1'b1;
						o_irq_epc <= pc;
						pc <= i_irq_pc;
					end else if (issue) begin
						// Fast jumps only move the pc
						if (i_class != CLASS_FAST_JUMP) begin
							data.strobe <= ~data.strobe;
							data.pc <= pc;
							data.instruction <= i_icache_rdata;
							data.inst_rs1 <= i_rs1;
							data.inst_rs2 <= i_rs2;
							data.inst_rs3 <= i_rs3;
							data.inst_rd <= i_rd;
						end

						case (i_class)
							CLASS_FAST_JUMP: begin
								pc <= pc + i_j_imm;
							end
							CLASS_WAIT_JUMP: begin
								state <= WAIT_JUMP;
							end
							CLASS_WAIT_IRQ: begin
								// Return point is the next instruction
								pc <= pc + 32'd4;
								state <= WAIT_IRQ;
							end
							default: begin
								pc <= pc + 32'd4;
							end
						endcase
					end
				end

				WAIT_JUMP: begin
					// Target comes from the execute side
					if (i_jump) begin
						pc <= i_jump_pc;
						state <= WAIT_ICACHE;
					end
				end

				WAIT_IRQ: begin
					irq_pending_r <= i_irq_pending;
					if (irq_edge) begin
						o_irq_dispatched <= 1'b1;
						o_irq_epc <= pc;
						pc <= i_irq_pc;
						state <= WAIT_ICACHE;
					end
				end

				default: begin
					state <= WAIT_ICACHE;
				end
			endcase
		end
	end

	irq_dispatch_single: assert property (@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |=> !o_irq_dispatched);

	strobe_held_while_busy: assert property (@(posedge i_clock) disable iff (i_reset)
		i_busy |=> $stable(o_data.strobe));

endmodule

// ==== src/instruction_predecode.sv ====
// Early decode of the cache word for the fetch unit
// Pure logic that gives the control-flow class, J immediate and operand indices

`timescale 1ns/1ps

module instruction_predecode (
	input rv_isa_pkg::instruction_t i_instruction,
	output rv_isa_pkg::inst_class_t o_class,
	output rv_isa_pkg::address_t o_j_imm,
	output rv_isa_pkg::register_t o_rs1,
	output rv_isa_pkg::register_t o_rs2,
	output rv_isa_pkg::register_t o_rs3,
	output rv_isa_pkg::register_t o_rd
);
	import rv_isa_pkg::*;

	opcode_t opcode;
	logic [2:0] funct3;
	logic [11:0] funct12;
	register_t rd_field;
	logic is_r, is_i, is_s, is_b, is_u, is_j, is_r4;
	logic is_system, is_priv, is_csr_reg, is_csr_imm;
	logic is_ecall, is_mret, is_wfi;
	logic have_rs1, have_rs2, have_rs3, have_rd;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign funct12 = i_instruction[31:20];
	assign rd_field = i_instruction[11:7];

	// Instruction formats
	assign is_r = opcode == OP_REG;
	assign is_i = opcode == OP_IMM || opcode == OP_LOAD || opcode == OP_JALR;
	assign is_s = opcode == OP_STORE;
	assign is_b = opcode == OP_BRANCH;
	assign is_u = opcode == OP_LUI || opcode == OP_AUIPC;
	assign is_j = opcode == OP_JAL;
	assign is_r4 = opcode == OP_MADD || opcode == OP_MSUB ||
		opcode == OP_NMSUB || opcode == OP_NMADD;

	// SYSTEM splits into privileged ops and CSR access
	assign is_system = opcode == OP_SYSTEM;
	assign is_priv = is_system && funct3 == 3'b000;
	assign is_csr_reg = is_system && funct3 != 3'b000 && !funct3[2];
	assign is_csr_imm = is_system && funct3[2];
	assign is_ecall = is_priv && funct12 == FUNCT12_ECALL;
	assign is_mret = is_priv && funct12 == FUNCT12_MRET;
	assign is_wfi = is_priv && funct12 == FUNCT12_WFI;

	// CSR immediate forms reuse the rs1 field as data
	assign have_rs1 = is_r || is_i || is_s || is_b || is_r4 || is_csr_reg;
	assign have_rs2 = is_r || is_s || is_b || is_r4;
	assign have_rs3 = is_r4;
	assign have_rd = is_r || is_i || is_u || is_j || is_r4 || is_csr_reg || is_csr_imm;

	assign o_rs1 = have_rs1 ? i_instruction[19:15] : '0;
	assign o_rs2 = have_rs2 ? i_instruction[24:20] : '0;
	assign o_rs3 = have_rs3 ? i_instruction[31:27] : '0;
	assign o_rd = have_rd ? rd_field : '0;

	assign o_j_imm = {{12{i_instruction[31]}}, i_instruction[19:12], i_instruction[20],
		i_instruction[30:21], 1'b0};

	always_comb begin
		if (is_j && rd_field == '0) begin
			o_class = CLASS_FAST_JUMP;
		end else if (is_j || is_b || opcode == OP_JALR || is_mret) begin
			o_class = CLASS_WAIT_JUMP;
		end else if (is_ecall || is_wfi) begin
			o_class = CLASS_WAIT_IRQ;
		end else begin
			o_class = CLASS_SEQUENTIAL;
		end
	end

endmodule

// ==== src/rv_isa_pkg.sv ====
// RV32I instruction-set types and field encodings
// Shared by the predecoder, the fetch unit and the cache

package rv_isa_pkg;

	typedef logic [4:0] register_t;
	typedef logic [31:0] instruction_t;
	typedef logic [31:0] address_t;
	typedef logic [6:0] opcode_t;

	// Base opcodes
	localparam opcode_t OP_LUI = 7'b0110111;
	localparam opcode_t OP_AUIPC = 7'b0010111;
	localparam opcode_t OP_JAL = 7'b1101111;
	localparam opcode_t OP_JALR = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD = 7'b0000011;
	localparam opcode_t OP_STORE = 7'b0100011;
	localparam opcode_t OP_IMM = 7'b0010011;
	localparam opcode_t OP_REG = 7'b0110011;
	localparam opcode_t OP_SYSTEM = 7'b1110011;

	// Fused multiply-add group is the only user of rs3
	localparam opcode_t OP_MADD = 7'b1000011;
	localparam opcode_t OP_MSUB = 7'b1000111;
	localparam opcode_t OP_NMSUB = 7'b1001011;
	localparam opcode_t OP_NMADD = 7'b1001111;

	// funct12 of privileged SYSTEM instructions
	localparam logic [11:0] FUNCT12_ECALL = 12'h000;
	localparam logic [11:0] FUNCT12_WFI = 12'h105;
	localparam logic [11:0] FUNCT12_MRET = 12'h302;

	typedef enum logic [1:0] {
		CLASS_SEQUENTIAL,
		CLASS_FAST_JUMP,
		CLASS_WAIT_JUMP,
		CLASS_WAIT_IRQ
	} inst_class_t;

endpackage

// ==== test/fetch_input.txt ====
# M address word | J packet delay jump_target | I packet delay irq_pc (packet counts from 1)
# E pc instruction rs1 rs2 rs3 rd, one per expected packet in order, indices in decimal
M 00000000 00510093
M 00000004 002081B3
M 00000008 00322423
M 0000000C 123452B7
M 00000010 0100006F
M 00000020 305203C3
M 00000024 FE208EE3
M 00000028 000300E7
M 00000030 00000073
M 00000034 00150513
M 00000038 008000EF
M 00000040 300413F3
M 00000044 3051D4F3
M 00000048 30200073
M 00000050 10500073
M 00000060 00D665B3
M 00000064 00000073
J 6 3 00000020
J 8 0 00000028
J 9 5 00000030
I 10 4 00000040
J 13 2 00000034
J 15 1 00000050
I 16 0 00000060
E 00000000 00510093 2 0 0 1
E 00000004 002081B3 1 2 0 3
E 00000008 00322423 4 3 0 0
E 0000000C 123452B7 0 0 0 5
E 00000020 305203C3 4 5 6 7
E 00000024 FE208EE3 1 2 0 0
E 00000020 305203C3 4 5 6 7
E 00000024 FE208EE3 1 2 0 0
E 00000028 000300E7 6 0 0 1
E 00000030 00000073 0 0 0 0
E 00000040 300413F3 8 0 0 7
E 00000044 3051D4F3 0 0 0 9
E 00000048 30200073 0 0 0 0
E 00000034 00150513 10 0 0 10
E 00000038 008000EF 0 0 0 1
E 00000050 10500073 0 0 0 0
E 00000060 00D665B3 12 13 0 11
E 00000064 00000073 0 0 0 0

// ==== test/tb_clock_gen.sv ====
// Clock and reset for the fetch stage testbench
// 100 ns clock with reset held high for the first 16 rising edges

`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #50 o_clock = ~o_clock;
	end

	// Released at a rising edge that still sees reset high
	initial begin
		o_reset = 1'b1;
		repeat (16) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

// ==== test/tb_fetch.sv ====
// Testbench for the fetch stage top level
// Replays test/fetch_input.txt with its program image, events and expected packets

`timescale 1ns/1ps

module tb_fetch;
	import rv_isa_pkg::*;
	import fetch_pkg::*;

	logic clock;
	logic reset;
	logic mem_req;
	address_t mem_address;
	logic mem_ack;
	instruction_t mem_rdata;
	logic busy;
	fetch_data_t data;
	logic jump;
	address_t jump_pc;
	logic irq_pending;
	address_t irq_pc;
	logic irq_dispatched;
	address_t irq_epc;

	instruction_t memory [address_t];
	fetch_data_t expected [$];
	// Control events, in packet order
	int event_packet [$];
	logic [7:0] event_kind [$];
	int event_delay [$];
	address_t event_target [$];

	int received;
	int cycles;
	int cycle_limit;
	int quiet_cycles;
	int ack_delay;
	int busy_hold;
	logic last_strobe;
	logic dispatch_seen;
	logic event_armed;
	logic [7:0] armed_kind;
	int armed_delay;
	address_t armed_target;
	address_t expected_epc;
	logic irq_waiting;

	tb_clock_gen clock_gen_inst (
		.o_clock(clock),
		.o_reset(reset)
	);

	fetch_top fetch_top_inst (
		.i_clock(clock),
		.i_reset(reset),
		.o_mem_req(mem_req),
		.o_mem_address(mem_address),
		.i_mem_ack(mem_ack),
		.i_mem_rdata(mem_rdata),
		.i_busy(busy),
		.o_data(data),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.i_irq_pending(irq_pending),
		.i_irq_pc(irq_pc),
		.o_irq_dispatched(irq_dispatched),
		.o_irq_epc(irq_epc)
	);

	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic fail_plain(string why);
		$display("ERROR: %s", why);
		abort_run();
	endtask

	task automatic check_packet(string name, fetch_data_t want, fetch_data_t got);
		if (got !== want) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, want, got);
			$display("  expected pc=%h inst=%h rs1=%0d rs2=%0d rs3=%0d rd=%0d",
				want.pc, want.instruction, want.inst_rs1, want.inst_rs2,
				want.inst_rs3, want.inst_rd);
			$display("  actual   pc=%h inst=%h rs1=%0d rs2=%0d rs3=%0d rd=%0d",
				got.pc, got.instruction, got.inst_rs1, got.inst_rs2,
				got.inst_rs3, got.inst_rd);
			abort_run();
		end
	endtask

	task automatic check_epc(string name, address_t want, address_t got);
		if (got !== want) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, want, got);
			abort_run();
		end
	endtask

	function automatic instruction_t read_word(address_t address);
		// Words outside the image read back their inverted address
		if (memory.exists(address)) begin
			return memory[address];
		end
		return ~address;
	endfunction

	task automatic load_input();
		int fd;
		int count;
		int packet;
		int delay;
		int r1, r2, r3, rd;
		logic [7:0] kind;
		string rest;
		address_t address;
		instruction_t word;
		fetch_data_t want;
		fd = $fopen("test/fetch_input.txt", "r");
		if (fd == 0) begin
			fail_plain("cannot open test/fetch_input.txt");
		end else begin
			while ($fscanf(fd, " %c", kind) == 1) begin
				case (kind)
					"#": count = $fgets(rest, fd);
					"M": begin
						count = $fscanf(fd, "%h %h", address, word);
						memory[address] = word;
					end
					"J", "I": begin
						count = $fscanf(fd, "%d %d %h", packet, delay, address);
						event_packet.push_back(packet);
						event_kind.push_back(kind);
						event_delay.push_back(delay);
						event_target.push_back(address);
					end
					"E": begin
						count = $fscanf(fd, "%h %h %d %d %d %d", address, word, r1, r2, r3, rd);
						// First packet flips the strobe from its reset value of zero
						want.strobe = (expected.size() % 2 == 0);
						want.pc = address;
						want.instruction = word;
						want.inst_rs1 = register_t'(r1);
						want.inst_rs2 = register_t'(r2);
						want.inst_rs3 = register_t'(r3);
						want.inst_rd = register_t'(rd);
						expected.push_back(want);
					end
					default: fail_plain("unknown line kind in test/fetch_input.txt");
				endcase
			end
			$fclose(fd);
		end
	endtask

	// Outputs are sampled on the falling edge half a cycle after they settle
	task automatic watch_outputs();
		if (data.strobe != last_strobe) begin
			if (busy) begin
				fail_plain("strobe flipped while busy was high");
			end else if (event_armed || irq_waiting) begin
				fail_plain("packet issued while waiting for a jump or an interrupt");
			end else if (received == expected.size()) begin
				fail_plain("packet issued after the end of the expected stream");
			end else begin
				check_packet($sformatf("packet %0d", received + 1), expected[received], data);
				received++;
				last_strobe = data.strobe;
			end
			if (event_packet.size() > 0 && event_packet[0] == received) begin
				event_armed = 1'b1;
				armed_kind = event_kind.pop_front();
				armed_delay = event_delay.pop_front();
				armed_target = event_target.pop_front();
				event_packet.delete(0);
				// Return point is the instruction after ECALL or WFI
				expected_epc = expected[received - 1].pc + 32'd4;
			end
		end
		if (irq_dispatched) begin
			if (dispatch_seen) begin
				fail_plain("irq dispatch stayed high for two cycles");
			end else if (!irq_waiting) begin
				fail_plain("irq dispatched without a pending request");
			end else begin
				check_epc($sformatf("irq return pc after packet %0d", received),
					expected_epc, irq_epc);
				irq_waiting = 1'b0;
				irq_pending = 1'b0;
			end
		end
		dispatch_seen = irq_dispatched;
	endtask

	task automatic drive_busy();
		int roll;
		roll = int'($urandom % 32);
		if (busy_hold > 0) begin
			busy = 1'b1;
			busy_hold--;
		end else if (roll == 0) begin
			busy = 1'b1;
			busy_hold = 24;
		end else begin
			busy = roll < 8;
		end
	endtask

	task automatic drive_control();
		jump = 1'b0;
		if (event_armed) begin
			if (armed_delay > 0) begin
				armed_delay--;
			end else if (armed_kind == "J") begin
				jump = 1'b1;
				jump_pc = armed_target;
				event_armed = 1'b0;
			end else begin
				irq_pc = armed_target;
				irq_pending = 1'b1;
				irq_waiting = 1'b1;
				event_armed = 1'b0;
			end
		end
	endtask

	// Four-phase responder with a random wait before each ack
	task automatic serve_memory();
		if (mem_ack && !mem_req) begin
			mem_ack = 1'b0;
		end else if (mem_req && !mem_ack) begin
			if (ack_delay < 0) begin
				ack_delay = int'($urandom % 6);
			end
			if (ack_delay == 0) begin
				mem_ack = 1'b1;
				mem_rdata = read_word(mem_address);
				ack_delay = -1;
			end else begin
				ack_delay--;
			end
		end
	endtask

	initial begin
		void'($urandom(32'h6fee_dff2));
		mem_ack = 1'b0;
		mem_rdata = '0;
		busy = 1'b0;
		jump = 1'b0;
		jump_pc = '0;
		irq_pending = 1'b0;
		irq_pc = '0;
		received = 0;
		cycles = 0;
		quiet_cycles = 0;
		ack_delay = -1;
		// Start with a long busy stretch over the first misses
		busy_hold = 30;
		last_strobe = 1'b0;
		dispatch_seen = 1'b0;
		event_armed = 1'b0;
		armed_kind = "J";
		armed_delay = 0;
		armed_target = '0;
		expected_epc = '0;
		irq_waiting = 1'b0;

		load_input();
		cycle_limit = 40 * expected.size() + 200;

		@(negedge clock);
		while (reset) begin
			@(negedge clock);
		end
		if (mem_req !== 1'b0 || irq_dispatched !== 1'b0 || data.strobe !== 1'b0) begin
			fail_plain("outputs not at their reset values after reset");
		end

		// Run on past the last packet to catch stray ones
		while (quiet_cycles < 30) begin
			watch_outputs();
			drive_busy();
			drive_control();
			serve_memory();
			cycles++;
			if (cycles >= cycle_limit) begin
				$display("Timeout after %0d cycles with %0d of %0d packets received",
					cycles, received, expected.size());
				abort_run();
			end
			if (received == expected.size()) begin
				quiet_cycles++;
			end
			@(negedge clock);
		end

		if (event_packet.size() != 0 || event_armed || irq_waiting) begin
			fail_plain("jump or interrupt events left unused at the end of the run");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule
